//--- src/ex_macros.svh
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

`default_nettype none

// Integer datapath width
`define EX_XLEN 32

// Cycles from mul_en to mul_ready
`define EX_MUL_LATENCY 3

// Cycles from div_en to div_ready, one per quotient bit plus load
`define EX_DIV_CYCLES 33

`default_nettype wire

`endif

//--- src/ex_pkg.sv
`include "ex_macros.svh"
`default_nettype none

package ex_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_ADDU,
		ALU_SUB,
		ALU_SUBU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_LUI
	} alu_op_e;

	typedef enum logic [1:0] {SFT_SLL, SFT_SRL, SFT_SRA} sft_op_e;

	// Stage result source
	typedef enum logic [2:0] {OUT_ALU, OUT_SFT, OUT_HI, OUT_LO, OUT_MUL_LO} out_sel_e;

	// DST_RA selects register 31
	typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} regdst_e;

	typedef enum logic [1:0] {HL_MUL, HL_DIV, HL_RS} hilo_src_e;

	// Decoded control word
	typedef struct packed {
		alu_op_e   alu_func;
		sft_op_e   sft_func;
		out_sel_e  out_sel;
		regdst_e   regdst;
		hilo_src_e hi_sel;
		hilo_src_e lo_sel;
		logic      imm_sign;
		logic      alu_srcb_sel_rt;
		logic      sft_srca_sel_imm;
		logic      sft_srcb_sel_rs;
		logic      intovf_en;
		logic      regwrite;
		logic      hi_wen;
		logic      lo_wen;
		logic      mul_en;
		logic      mul_sign;
		logic      div_en;
		logic      div_sign;
	} ctrl_reg;

	typedef struct packed {
		logic [`EX_XLEN-1:0] pc;
		logic [15:0]         imm;
		logic [4:0]          sa;
		logic [4:0]          rs;
		logic [4:0]          rt;
		logic [4:0]          rd;
		logic                in_delay_slot;
		logic                is_instr;
	} dp_dtoe;

	typedef struct packed {
		logic [`EX_XLEN-1:0] ex_out;
		logic [4:0]          reg_waddr;
		logic [`EX_XLEN-1:0] hi_wdata;
		logic [`EX_XLEN-1:0] lo_wdata;
		logic                intovf;
		logic [`EX_XLEN-1:0] pc;
		logic [`EX_XLEN-1:0] rsdata;
		logic [`EX_XLEN-1:0] rtdata;
		logic                in_delay_slot;
		logic                is_instr;
	} dp_etom;

	// Signals seen by the hazard unit
	typedef struct packed {
		logic       mul_ready;
		logic       div_ready;
		logic [4:0] reg_waddr;
		logic       regwrite;
		logic       hi_wen;
		logic       lo_wen;
		logic       mul_en;
		logic       div_en;
		logic [4:0] rs;
		logic [4:0] rt;
	} dp_etoh;

endpackage

`default_nettype wire

//--- src/alu.sv
`timescale 1ns/1ps
`include "ex_macros.svh"
`default_nettype none

module alu (
	input  ex_pkg::alu_op_e      func,
	input  logic [`EX_XLEN-1:0] srca,
	input  logic [`EX_XLEN-1:0] srcb,
	output logic [`EX_XLEN-1:0] out,
	output logic                intovf
);

	localparam int W = `EX_XLEN;

	logic [W-1:0] sum;
	logic [W-1:0] diff;
	logic         ovf_add;
	logic         ovf_sub;
	logic         lt_s;
	logic         lt_u;

	assign sum  = srca + srcb;
	assign diff = srca - srcb;

	// Same operand signs but result sign flipped
	assign ovf_add = (srca[W-1] == srcb[W-1]) && (sum[W-1] != srca[W-1]);
	// Differing signs and result takes the subtrahend's sign
	assign ovf_sub = (srca[W-1] != srcb[W-1]) && (diff[W-1] != srca[W-1]);

	assign lt_s = $signed(srca) < $signed(srcb);
	assign lt_u = srca < srcb;

	always_comb begin
		out    = '0;
		intovf = 1'b0;
		case (func)
			ex_pkg::ALU_ADD: begin
				out    = sum;
				intovf = ovf_add;
			end
			ex_pkg::ALU_ADDU: out = sum;
			ex_pkg::ALU_SUB: begin
				out    = diff;
				intovf = ovf_sub;
			end
			ex_pkg::ALU_SUBU: out = diff;
			ex_pkg::ALU_AND:  out = srca & srcb;
			ex_pkg::ALU_OR:   out = srca | srcb;
			ex_pkg::ALU_XOR:  out = srca ^ srcb;
			ex_pkg::ALU_NOR:  out = ~(srca | srcb);
			ex_pkg::ALU_SLT:  out = {{(W-1){1'b0}}, lt_s};
			ex_pkg::ALU_SLTU: out = {{(W-1){1'b0}}, lt_u};
			// Low half of srcb moved to the upper half
			ex_pkg::ALU_LUI:  out = {srcb[W/2-1:0], {(W/2){1'b0}}};
			default:          out = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/shifter.sv
`timescale 1ns/1ps
`include "ex_macros.svh"
`default_nettype none

module shifter (
	input  logic [`EX_XLEN-1:0] srca,
	input  logic [4:0]          srcb,
	input  ex_pkg::sft_op_e      func,
	output logic [`EX_XLEN-1:0] out
);

	always_comb begin
		case (func)
			ex_pkg::SFT_SLL: out = srca << srcb;
			ex_pkg::SFT_SRL: out = srca >> srcb;
			// Sign fill from bit 31
			ex_pkg::SFT_SRA: out = $unsigned($signed(srca) >>> srcb);
			default:         out = srca;
		endcase
	end

endmodule

`default_nettype wire

//--- src/multiplier.sv
`timescale 1ns/1ps
`include "ex_macros.svh"
`default_nettype none

module multiplier (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  logic                sign,
	input  logic [`EX_XLEN-1:0] srca,
	input  logic [`EX_XLEN-1:0] srcb,
	output logic                out_valid,
	output logic [`EX_XLEN-1:0] hi,
	output logic [`EX_XLEN-1:0] lo
);

	localparam int W = `EX_XLEN;
	localparam int H = W / 2;

	logic [2:0]     vld;
	logic [W-1:0]   mag_a;
	logic [W-1:0]   mag_b;
	logic [W-1:0]   s1_a;
	logic [W-1:0]   s1_b;
	logic           s1_neg;
	logic [W-1:0]   s2_ll;
	logic [W-1:0]   s2_lh;
	logic [W-1:0]   s2_hl;
	logic [W-1:0]   s2_hh;
	logic           s2_neg;
	logic [2*W-1:0] sum;
	logic [2*W-1:0] s3_prod;

	// Magnitudes, so the array below is always unsigned
	assign mag_a = (sign && srca[W-1]) ? -srca : srca;
	assign mag_b = (sign && srcb[W-1]) ? -srcb : srcb;

	// Cross terms land in the middle of the 64-bit product
	assign sum = {s2_hh, s2_ll}
		+ {{H{1'b0}}, s2_lh, {H{1'b0}}}
		+ {{H{1'b0}}, s2_hl, {H{1'b0}}};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld     <= '0;
			s1_a    <= '0;
			s1_b    <= '0;
			s1_neg  <= 1'b0;
			s2_ll   <= '0;
			s2_lh   <= '0;
			s2_hl   <= '0;
			s2_hh   <= '0;
			s2_neg  <= 1'b0;
			s3_prod <= '0;
		end else begin
			vld     <= {vld[1:0], in_valid};
			// Stage 1 operand magnitudes and result sign
			s1_a    <= mag_a;
			s1_b    <= mag_b;
			s1_neg  <= sign & (srca[W-1] ^ srcb[W-1]);
			// Stage 2 half-width partial products
			s2_ll   <= s1_a[H-1:0] * s1_b[H-1:0];
			s2_lh   <= s1_a[H-1:0] * s1_b[W-1:H];
			s2_hl   <= s1_a[W-1:H] * s1_b[H-1:0];
			s2_hh   <= s1_a[W-1:H] * s1_b[W-1:H];
			s2_neg  <= s1_neg;
			// Stage 3 sum with sign correction
			s3_prod <= s2_neg ? -sum : sum;
		end
	end

	assign out_valid = vld[2];
	assign hi        = s3_prod[2*W-1:W];
	assign lo        = s3_prod[W-1:0];

endmodule

`default_nettype wire

//--- src/divider.sv
`timescale 1ns/1ps
`include "ex_macros.svh"
`default_nettype none

module divider (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  logic                sign,
	input  logic [`EX_XLEN-1:0] srca,
	input  logic [`EX_XLEN-1:0] srcb,
	output logic                out_valid,
	output logic [`EX_XLEN-1:0] hi,
	output logic [`EX_XLEN-1:0] lo
);

	localparam int W = `EX_XLEN;
	// Counter value on the last quotient bit
	localparam logic [5:0] CNT_LAST = 6'(`EX_DIV_CYCLES - 2);

	typedef enum logic [1:0] {IDLE, RUN, DONE} state_e;

	state_e       state;
	logic [5:0]   cnt;
	logic [W-1:0] rem;
	logic [W-1:0] quo;
	logic [W-1:0] dvs;
	logic         q_neg;
	logic         r_neg;
	logic [W-1:0] mag_a;
	logic [W-1:0] mag_b;
	logic [W:0]   shifted;
	logic [W:0]   trial;

	assign mag_a = (sign && srca[W-1]) ? -srca : srca;
	assign mag_b = (sign && srcb[W-1]) ? -srcb : srcb;

	// Next dividend bit enters the partial remainder
	assign shifted = {rem, quo[W-1]};
	assign trial   = shifted - {1'b0, dvs};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			cnt   <= '0;
			rem   <= '0;
			quo   <= '0;
			dvs   <= '0;
			q_neg <= 1'b0;
			r_neg <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (in_valid) begin
						rem   <= '0;
						quo   <= mag_a;
						dvs   <= mag_b;
						// A zero divisor leaves the all-ones quotient unnegated
						q_neg <= sign & (srca[W-1] ^ srcb[W-1]) & (|srcb);
						r_neg <= sign & srca[W-1];
						cnt   <= '0;
						state <= RUN;
					end
				end
				RUN: begin
					if (!trial[W]) begin
						rem <= trial[W-1:0];
						quo <= {quo[W-2:0], 1'b1};
					end else begin
						rem <= shifted[W-1:0];
						quo <= {quo[W-2:0], 1'b0};
					end
					cnt <= cnt + 6'd1;
					if (cnt == CNT_LAST)
						state <= DONE;
				end
				DONE:    state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign out_valid = (state == DONE);
	// Remainder follows the dividend's sign
	assign hi = r_neg ? -rem : rem;
	assign lo = q_neg ? -quo : quo;

endmodule

`default_nettype wire

//--- src/ex.sv
`timescale 1ns/1ps
`include "ex_macros.svh"
`default_nettype none

module ex (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [`EX_XLEN-1:0] e_for_rsdata,
	input  logic [`EX_XLEN-1:0] e_for_rtdata,
	input  ex_pkg::dp_dtoe       dtoe,
	input  ex_pkg::ctrl_reg      esig,
	input  logic [`EX_XLEN-1:0] hi_cur,
	input  logic [`EX_XLEN-1:0] lo_cur,
	output ex_pkg::dp_etom       etom,
	output ex_pkg::dp_etoh       etoh
);

	localparam int W = `EX_XLEN;

	logic [W-1:0] imm_ext;
	logic [W-1:0] alu_srcb;
	logic [W-1:0] alu_out;
	logic         alu_intovf;
	logic [W-1:0] sft_srca;
	logic [4:0]   sft_srcb;
	logic [W-1:0] sft_out;
	logic         mul_ready;
	logic [W-1:0] mul_hi;
	logic [W-1:0] mul_lo;
	logic         div_ready;
	logic [W-1:0] div_hi;
	logic [W-1:0] div_lo;
	logic [W-1:0] ex_out;
	logic [4:0]   reg_waddr;

	// HI and LO write data share one source select
	function automatic logic [W-1:0] hilo_pick(ex_pkg::hilo_src_e src, logic [W-1:0] from_mul,
			logic [W-1:0] from_div, logic [W-1:0] from_rs);
		case (src)
			ex_pkg::HL_MUL: return from_mul;
			ex_pkg::HL_DIV: return from_div;
			ex_pkg::HL_RS:  return from_rs;
			default:        return '0;
		endcase
	endfunction

	assign imm_ext  = esig.imm_sign ? {{(W-16){dtoe.imm[15]}}, dtoe.imm}
		: {{(W-16){1'b0}}, dtoe.imm};
	assign alu_srcb = esig.alu_srcb_sel_rt ? e_for_rtdata : imm_ext;
	assign sft_srca = esig.sft_srca_sel_imm ? imm_ext : e_for_rtdata;
	// Variable shifts take the count from rs
	assign sft_srcb = esig.sft_srcb_sel_rs ? e_for_rsdata[4:0] : dtoe.sa;

	alu u_alu (
		.func   (esig.alu_func),
		.srca   (e_for_rsdata),
		.srcb   (alu_srcb),
		.out    (alu_out),
		.intovf (alu_intovf)
	);

	shifter u_shifter (
		.srca (sft_srca),
		.srcb (sft_srcb),
		.func (esig.sft_func),
		.out  (sft_out)
	);

	multiplier u_mul (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (esig.mul_en),
		.sign      (esig.mul_sign),
		.srca      (e_for_rsdata),
		.srcb      (e_for_rtdata),
		.out_valid (mul_ready),
		.hi        (mul_hi),
		.lo        (mul_lo)
	);

	divider u_div (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (esig.div_en),
		.sign      (esig.div_sign),
		.srca      (e_for_rsdata),
		.srcb      (e_for_rtdata),
		.out_valid (div_ready),
		.hi        (div_hi),
		.lo        (div_lo)
	);

	always_comb begin
		case (esig.out_sel)
			ex_pkg::OUT_ALU:    ex_out = alu_out;
			ex_pkg::OUT_SFT:    ex_out = sft_out;
			ex_pkg::OUT_HI:     ex_out = hi_cur;
			ex_pkg::OUT_LO:     ex_out = lo_cur;
			ex_pkg::OUT_MUL_LO: ex_out = mul_lo;
			default:            ex_out = '0;
		endcase
		case (esig.regdst)
			ex_pkg::DST_RT: reg_waddr = dtoe.rt;
			ex_pkg::DST_RD: reg_waddr = dtoe.rd;
			ex_pkg::DST_RA: reg_waddr = 5'd31;
			default:        reg_waddr = dtoe.rt;
		endcase
	end

	// Memory stage bundle
	always_comb begin
		etom.ex_out        = ex_out;
		etom.reg_waddr     = reg_waddr;
		etom.hi_wdata      = hilo_pick(esig.hi_sel, mul_hi, div_hi, e_for_rsdata);
		etom.lo_wdata      = hilo_pick(esig.lo_sel, mul_lo, div_lo, e_for_rsdata);
		etom.intovf        = alu_intovf & esig.intovf_en;
		etom.pc            = dtoe.pc;
		etom.rsdata        = e_for_rsdata;
		etom.rtdata        = e_for_rtdata;
		etom.in_delay_slot = dtoe.in_delay_slot;
		etom.is_instr      = dtoe.is_instr;
	end

	// Hazard unit bundle
	always_comb begin
		etoh.mul_ready = mul_ready;
		etoh.div_ready = div_ready;
		etoh.reg_waddr = reg_waddr;
		etoh.regwrite  = esig.regwrite;
		etoh.hi_wen    = esig.hi_wen;
		etoh.lo_wen    = esig.lo_wen;
		etoh.mul_en    = esig.mul_en;
		etoh.div_en    = esig.div_en;
		etoh.rs        = dtoe.rs;
		etoh.rt        = dtoe.rt;
	end

endmodule

`default_nettype wire

//--- src/hilo_regs.sv
`timescale 1ns/1ps
`include "ex_macros.svh"
`default_nettype none

module hilo_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [`EX_XLEN-1:0] hi_wdata,
	input  logic [`EX_XLEN-1:0] lo_wdata,
	input  logic                hi_wen,
	input  logic                lo_wen,
	input  ex_pkg::hilo_src_e    hi_sel,
	input  ex_pkg::hilo_src_e    lo_sel,
	input  logic                mul_ready,
	input  logic                div_ready,
	output logic [`EX_XLEN-1:0] hi,
	output logic [`EX_XLEN-1:0] lo
);

	logic hi_we;
	logic lo_we;

	// RS data is ready at once, unit results only on their done pulse
	function automatic logic src_ready(ex_pkg::hilo_src_e src, logic mul_rdy, logic div_rdy);
		case (src)
			ex_pkg::HL_MUL: return mul_rdy;
			ex_pkg::HL_DIV: return div_rdy;
			ex_pkg::HL_RS:  return 1'b1;
			default:        return 1'b0;
		endcase
	endfunction

	assign hi_we = hi_wen & src_ready(hi_sel, mul_ready, div_ready);
	assign lo_we = lo_wen & src_ready(lo_sel, mul_ready, div_ready);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hi <= '0;
			lo <= '0;
		end else begin
			if (hi_we)
				hi <= hi_wdata;
			if (lo_we)
				lo <= lo_wdata;
		end
	end

endmodule

`default_nettype wire

//--- src/ex_top.sv
`timescale 1ns/1ps
`include "ex_macros.svh"
`default_nettype none

module ex_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [`EX_XLEN-1:0] rsdata,
	input  logic [`EX_XLEN-1:0] rtdata,
	input  ex_pkg::dp_dtoe       dtoe,
	input  ex_pkg::ctrl_reg      esig,
	output ex_pkg::dp_etom       etom,
	output ex_pkg::dp_etoh       etoh
);

	logic [`EX_XLEN-1:0] hi_cur;
	logic [`EX_XLEN-1:0] lo_cur;

	ex u_ex (
		.clk          (clk),
		.rst_n        (rst_n),
		.e_for_rsdata (rsdata),
		.e_for_rtdata (rtdata),
		.dtoe         (dtoe),
		.esig         (esig),
		.hi_cur       (hi_cur),
		.lo_cur       (lo_cur),
		.etom         (etom),
		.etoh         (etoh)
	);

	// Write enables and ready pulses come back from the stage
	hilo_regs u_hilo (
		.clk       (clk),
		.rst_n     (rst_n),
		.hi_wdata  (etom.hi_wdata),
		.lo_wdata  (etom.lo_wdata),
		.hi_wen    (etoh.hi_wen),
		.lo_wen    (etoh.lo_wen),
		.hi_sel    (esig.hi_sel),
		.lo_sel    (esig.lo_sel),
		.mul_ready (etoh.mul_ready),
		.div_ready (etoh.div_ready),
		.hi        (hi_cur),
		.lo        (lo_cur)
	);

endmodule

`default_nettype wire

//--- bench/ex_assert.sv
`timescale 1ns/1ps
`include "ex_macros.svh"
`default_nettype none

module ex_assert (
	input logic           clk,
	input logic           rst_n,
	input ex_pkg::dp_etoh etoh
);

	logic [5:0] div_left;

	// Cycles until the divider is free again
	always_ff @(posedge clk) begin
		if (!rst_n)
			div_left <= '0;
		else if (etoh.div_en && div_left == 6'd0)
			div_left <= 6'(`EX_DIV_CYCLES);
		else if (div_left != 6'd0)
			div_left <= div_left - 6'd1;
	end

	a_mul_latency: assert property (@(posedge clk) disable iff (!rst_n)
		etoh.mul_en |-> ##(`EX_MUL_LATENCY) etoh.mul_ready)
		else $error("mul_ready missing after mul_en");

	a_mul_origin: assert property (@(posedge clk) disable iff (!rst_n)
		etoh.mul_ready |-> $past(etoh.mul_en, `EX_MUL_LATENCY))
		else $error("mul_ready without a matching mul_en");

	a_div_latency: assert property (@(posedge clk) disable iff (!rst_n)
		etoh.div_ready |-> $past(etoh.div_en, `EX_DIV_CYCLES))
		else $error("div_ready without a matching div_en");

	a_div_busy: assert property (@(posedge clk) disable iff (!rst_n)
		etoh.div_en |-> div_left == 6'd0)
		else $error("div_en while the divider is busy");

endmodule

`default_nettype wire

//--- bench/ex_checker.sv
`timescale 1ns/1ps
`include "ex_macros.svh"
`default_nettype none

module ex_checker (
	input ex_pkg::dp_etom etom,
	input ex_pkg::dp_etoh etoh
);

	int n_pass;
	int n_fail;

	initial begin
		n_pass = 0;
		n_fail = 0;
	end

	// One line per finished test
	task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp === act) begin
			n_pass++;
			$display("[PASS] %s", name);
		end else begin
			n_fail++;
			$display("[FAIL] %s expected %08h actual %08h", name, exp, act);
		end
	endtask

	task automatic check_out(input string name, input logic [31:0] exp);
		report(name, exp, etom.ex_out);
	endtask

	task automatic check_waddr(input string name, input logic [4:0] exp);
		report(name, {27'h0, exp}, {27'h0, etom.reg_waddr});
		report({name, " hazard"}, {27'h0, exp}, {27'h0, etoh.reg_waddr});
	endtask

	task automatic check_ovf(input string name, input logic exp);
		report(name, {31'h0, exp}, {31'h0, etom.intovf});
	endtask

	// Ready pulse expected high or low in this very cycle
	task automatic check_ready(input string name, input logic is_div, input logic exp_rdy);
		report(name, {31'h0, exp_rdy}, {31'h0, is_div ? etoh.div_ready : etoh.mul_ready});
	endtask

	// Fields that the stage forwards unchanged
	task automatic compare_passthru(input string name, input ex_pkg::ctrl_reg c,
			input ex_pkg::dp_dtoe d, input logic [31:0] rs, input logic [31:0] rt);
		report({name, " pc"}, d.pc, etom.pc);
		report({name, " rsdata"}, rs, etom.rsdata);
		report({name, " rtdata"}, rt, etom.rtdata);
		report({name, " flags"}, {30'h0, d.in_delay_slot, d.is_instr},
			{30'h0, etom.in_delay_slot, etom.is_instr});
		report({name, " hazard"},
			{17'h0, c.regwrite, c.hi_wen, c.lo_wen, c.mul_en, c.div_en, d.rs, d.rt},
			{17'h0, etoh.regwrite, etoh.hi_wen, etoh.lo_wen, etoh.mul_en, etoh.div_en,
				etoh.rs, etoh.rt});
	endtask

	task automatic summary();
		$display("Checks: %0d passed, %0d failed", n_pass, n_fail);
	endtask

endmodule

`default_nettype wire

//--- bench/tb_ex.sv
`timescale 1ns/1ps
`include "ex_macros.svh"
`default_nettype none

module tb_ex;

	localparam int MUL_WAIT = `EX_MUL_LATENCY + 4;
	localparam int DIV_WAIT = `EX_DIV_CYCLES + 4;

	typedef struct packed {
		logic [31:0] out;
		logic [4:0]  waddr;
		logic        ovf;
		logic [31:0] hi;
		logic [31:0] lo;
	} model_t;

	logic            clk;
	logic            rst_n;
	logic [31:0]     rsdata;
	logic [31:0]     rtdata;
	ex_pkg::dp_dtoe  dtoe;
	ex_pkg::ctrl_reg esig;
	ex_pkg::dp_etom  etom;
	ex_pkg::dp_etoh  etoh;
	// Expected HI and LO contents
	logic [31:0]     hi_m;
	logic [31:0]     lo_m;
	integer          seed;
	model_t          exp;

	ex_top dut0 (
		.clk    (clk),
		.rst_n  (rst_n),
		.rsdata (rsdata),
		.rtdata (rtdata),
		.dtoe   (dtoe),
		.esig   (esig),
		.etom   (etom),
		.etoh   (etoh)
	);

	ex_checker chk0 (
		.etom (etom),
		.etoh (etoh)
	);

	bind ex_top ex_assert asrt0 (
		.clk   (clk),
		.rst_n (rst_n),
		.etoh  (etoh)
	);

	always #50 clk = ~clk;

	function automatic model_t ex_model(ex_pkg::ctrl_reg c, ex_pkg::dp_dtoe d,
			logic [31:0] rs, logic [31:0] rt, logic [31:0] hi_in, logic [31:0] lo_in);
		model_t      m;
		logic [31:0] imm;
		logic [31:0] b;
		logic [31:0] sft_in;
		logic [4:0]  sh;
		logic [63:0] wide;
		logic [63:0] prod;
		logic [63:0] tmp;
		logic [31:0] alu;
		logic        ovf;
		logic [31:0] sft;
		logic [31:0] q;
		logic [31:0] r;
		imm = c.imm_sign ? {{16{d.imm[15]}}, d.imm} : {16'h0, d.imm};
		b = c.alu_srcb_sel_rt ? rt : imm;
		ovf = 1'b0;
		alu = 32'h0;
		case (c.alu_func)
			ex_pkg::ALU_ADD, ex_pkg::ALU_ADDU: begin
				wide = {{32{rs[31]}}, rs} + {{32{b[31]}}, b};
				alu = wide[31:0];
				ovf = (c.alu_func == ex_pkg::ALU_ADD) && (wide[32] != wide[31]);
			end
			ex_pkg::ALU_SUB, ex_pkg::ALU_SUBU: begin
				wide = {{32{rs[31]}}, rs} - {{32{b[31]}}, b};
				alu = wide[31:0];
				ovf = (c.alu_func == ex_pkg::ALU_SUB) && (wide[32] != wide[31]);
			end
			ex_pkg::ALU_AND:  alu = rs & b;
			ex_pkg::ALU_OR:   alu = rs | b;
			ex_pkg::ALU_XOR:  alu = rs ^ b;
			ex_pkg::ALU_NOR:  alu = ~(rs | b);
			ex_pkg::ALU_SLT:  alu = {31'h0, $signed(rs) < $signed(b)};
			ex_pkg::ALU_SLTU: alu = {31'h0, rs < b};
			ex_pkg::ALU_LUI:  alu = {b[15:0], 16'h0};
			default:          alu = 32'h0;
		endcase
		sft_in = c.sft_srca_sel_imm ? imm : rt;
		sh = c.sft_srcb_sel_rs ? rs[4:0] : d.sa;
		wide = {{32{sft_in[31]}}, sft_in} >> sh;
		case (c.sft_func)
			ex_pkg::SFT_SLL: sft = sft_in << sh;
			ex_pkg::SFT_SRL: sft = sft_in >> sh;
			default:         sft = wide[31:0];
		endcase
		if (c.mul_sign)
			prod = $signed({{32{rs[31]}}, rs}) * $signed({{32{rt[31]}}, rt});
		else
			prod = {32'h0, rs} * {32'h0, rt};
		// Zero divisor gives all ones and the dividend back
		if (rt == 32'h0) begin
			q = 32'hffff_ffff;
			r = rs;
		end else if (c.div_sign) begin
			tmp = $signed({{32{rs[31]}}, rs}) / $signed({{32{rt[31]}}, rt});
			q = tmp[31:0];
			tmp = $signed({{32{rs[31]}}, rs}) % $signed({{32{rt[31]}}, rt});
			r = tmp[31:0];
		end else begin
			q = rs / rt;
			r = rs % rt;
		end
		m.hi = hi_in;
		m.lo = lo_in;
		if (c.hi_wen)
			m.hi = (c.hi_sel == ex_pkg::HL_MUL) ? prod[63:32]
				: (c.hi_sel == ex_pkg::HL_DIV) ? r : rs;
		if (c.lo_wen)
			m.lo = (c.lo_sel == ex_pkg::HL_MUL) ? prod[31:0]
				: (c.lo_sel == ex_pkg::HL_DIV) ? q : rs;
		case (c.out_sel)
			ex_pkg::OUT_ALU: m.out = alu;
			ex_pkg::OUT_SFT: m.out = sft;
			ex_pkg::OUT_HI:  m.out = hi_in;
			ex_pkg::OUT_LO:  m.out = lo_in;
			default:         m.out = prod[31:0];
		endcase
		case (c.regdst)
			ex_pkg::DST_RD: m.waddr = d.rd;
			ex_pkg::DST_RA: m.waddr = 5'd31;
			default:        m.waddr = d.rt;
		endcase
		m.ovf = ovf & c.intovf_en;
		return m;
	endfunction

	function automatic ex_pkg::dp_dtoe make_dtoe(logic [15:0] imm, logic [4:0] sa);
		ex_pkg::dp_dtoe d;
		d = '0;
		d.pc = 32'h0000_1000;
		d.imm = imm;
		d.sa = sa;
		d.rs = 5'd3;
		d.rt = 5'd7;
		d.rd = 5'd19;
		d.is_instr = 1'b1;
		return d;
	endfunction

	task automatic drive(input ex_pkg::ctrl_reg c, input ex_pkg::dp_dtoe d,
			input logic [31:0] a, input logic [31:0] b);
		@(posedge clk);
		esig <= c;
		dtoe <= d;
		rsdata <= a;
		rtdata <= b;
	endtask

	task automatic wait_ready(input logic is_div);
		int n;
		n = 0;
		while (!(is_div ? etoh.div_ready : etoh.mul_ready)
				&& n < (is_div ? DIV_WAIT : MUL_WAIT)) begin
			@(negedge clk);
			n++;
		end
		if (!(is_div ? etoh.div_ready : etoh.mul_ready)) begin
			$display("Timeout: no %s ready pulse within %0d cycles", is_div ? "div" : "mul", n);
			$display("*** TEST FAILED ***");
			$finish;
		end
	endtask

	task automatic run_comb(input string name, input ex_pkg::ctrl_reg c, input ex_pkg::dp_dtoe d,
			input logic [31:0] a, input logic [31:0] b);
		drive(c, d, a, b);
		exp = ex_model(c, d, a, b, hi_m, lo_m);
		@(negedge clk);
		chk0.check_out(name, exp.out);
		chk0.check_ovf({name, " ovf"}, exp.ovf);
	endtask

	task automatic read_hilo(input string name);
		ex_pkg::ctrl_reg c;
		c = '0;
		c.out_sel = ex_pkg::OUT_HI;
		drive(c, make_dtoe(16'h0, 5'd0), 32'h0, 32'h0);
		@(negedge clk);
		chk0.check_out({name, " hi"}, hi_m);
		c.out_sel = ex_pkg::OUT_LO;
		drive(c, make_dtoe(16'h0, 5'd0), 32'h0, 32'h0);
		@(negedge clk);
		chk0.check_out({name, " lo"}, lo_m);
	endtask

	// Start pulse, hold the operands until the done pulse, then read back
	task automatic run_long(input string name, input logic is_div, input logic sgn,
			input logic hi_en, input logic lo_en, input logic [31:0] a, input logic [31:0] b);
		ex_pkg::ctrl_reg c;
		ex_pkg::dp_dtoe  d;
		c = '0;
		d = make_dtoe(16'h0, 5'd0);
		c.mul_en = !is_div;
		c.mul_sign = sgn;
		c.div_en = is_div;
		c.div_sign = sgn;
		c.hi_wen = hi_en;
		c.lo_wen = lo_en;
		c.hi_sel = is_div ? ex_pkg::HL_DIV : ex_pkg::HL_MUL;
		c.lo_sel = c.hi_sel;
		c.out_sel = ex_pkg::OUT_MUL_LO;
		exp = ex_model(c, d, a, b, hi_m, lo_m);
		drive(c, d, a, b);
		c.mul_en = 1'b0;
		c.div_en = 1'b0;
		drive(c, d, a, b);
		@(negedge clk);
		wait_ready(is_div);
		if (!is_div)
			chk0.check_out({name, " mul_lo"}, exp.out);
		hi_m = exp.hi;
		lo_m = exp.lo;
		read_hilo(name);
	endtask

	task automatic write_rs(input string name, input logic to_hi, input logic [31:0] val);
		ex_pkg::ctrl_reg c;
		c = '0;
		c.hi_wen = to_hi;
		c.lo_wen = !to_hi;
		c.hi_sel = ex_pkg::HL_RS;
		c.lo_sel = ex_pkg::HL_RS;
		exp = ex_model(c, make_dtoe(16'h0, 5'd0), val, 32'h0, hi_m, lo_m);
		drive(c, make_dtoe(16'h0, 5'd0), val, 32'h0);
		hi_m = exp.hi;
		lo_m = exp.lo;
		read_hilo(name);
	endtask

	task automatic mul_burst();
		ex_pkg::ctrl_reg c;
		ex_pkg::dp_dtoe  d;
		logic [31:0]     a [3];
		logic [31:0]     b [3];
		logic [31:0]     want [3];
		c = '0;
		d = make_dtoe(16'h0, 5'd0);
		c.mul_en = 1'b1;
		c.mul_sign = 1'b1;
		c.out_sel = ex_pkg::OUT_MUL_LO;
		for (int i = 0; i < 3; i++) begin
			a[i] = $random(seed);
			b[i] = $random(seed);
			exp = ex_model(c, d, a[i], b[i], hi_m, lo_m);
			want[i] = exp.out;
			drive(c, d, a[i], b[i]);
		end
		c.mul_en = 1'b0;
		drive(c, d, 32'h0, 32'h0);
		@(negedge clk);
		wait_ready(1'b0);
		// First pulse found by the wait
		for (int i = 0; i < 3; i++) begin
			if (i > 0) begin
				@(negedge clk);
				chk0.check_ready($sformatf("burst ready %0d", i), 1'b0, 1'b1);
			end
			chk0.check_out($sformatf("burst product %0d", i), want[i]);
		end
		@(negedge clk);
		chk0.check_ready("burst ready end", 1'b0, 1'b0);
	endtask

	initial begin
		ex_pkg::ctrl_reg c;
		ex_pkg::dp_dtoe  d;
		ex_pkg::alu_op_e op;
		ex_pkg::sft_op_e so;
		logic [4:0]      cnt [3];
		logic [31:0]     op_a;
		logic [31:0]     op_b;
		seed = 30394;
		clk = 1'b0;
		rst_n = 1'b0;
		rsdata = 32'h0;
		rtdata = 32'h0;
		dtoe = '0;
		esig = '0;
		hi_m = 32'h0;
		lo_m = 32'h0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		// ALU on the immediate and rt paths
		for (int i = 0; i < 11; i++) begin
			op = ex_pkg::alu_op_e'(4'(i));
			c = '0;
			c.alu_func = op;
			c.intovf_en = 1'b1;
			c.imm_sign = 1'b1;
			run_comb({op.name(), " simm"}, c, make_dtoe(16'h8001 ^ 16'(i), 5'd0),
				$random(seed), 0);
			c.imm_sign = 1'b0;
			run_comb({op.name(), " zimm"}, c, make_dtoe(16'hf00f, 5'd0), $random(seed), 0);
			c.alu_srcb_sel_rt = 1'b1;
			run_comb({op.name(), " rt"}, c, make_dtoe(16'h0, 5'd0), $random(seed), $random(seed));
		end
		c = '0;
		c.alu_srcb_sel_rt = 1'b1;
		for (int e = 0; e < 2; e++) begin
			c.intovf_en = e[0];
			c.alu_func = ex_pkg::ALU_ADD;
			run_comb($sformatf("add ovf en%0d", e), c, make_dtoe(16'h0, 5'd0),
				32'h7fff_ffff, 32'h1);
			c.alu_func = ex_pkg::ALU_SUB;
			run_comb($sformatf("sub ovf en%0d", e), c, make_dtoe(16'h0, 5'd0),
				32'h8000_0000, 32'h1);
		end

		// Shifts by sa and by rs
		cnt[0] = 5'd0;
		cnt[1] = 5'd31;
		cnt[2] = 5'd13;
		for (int j = 0; j < 3; j++) begin
			so = ex_pkg::sft_op_e'(2'(j));
			c = '0;
			c.sft_func = so;
			c.out_sel = ex_pkg::OUT_SFT;
			for (int k = 0; k < 3; k++) begin
				c.sft_srcb_sel_rs = 1'b0;
				run_comb($sformatf("%s sa %0d", so.name(), cnt[k]), c,
					make_dtoe(16'h0, cnt[k]), 32'h0, 32'h8000_1234);
				c.sft_srcb_sel_rs = 1'b1;
				run_comb($sformatf("%s rs %0d", so.name(), cnt[k]), c,
					make_dtoe(16'h0, 5'd0), {27'h5, cnt[k]}, $random(seed));
			end
		end

		// Multiply and divide with HI/LO readback
		for (int s = 0; s < 2; s++) begin
			run_long($sformatf("mul s%0d min", s), 1'b0, s[0], 1'b1, 1'b1,
				32'h8000_0000, 32'hffff_ffff);
			run_long($sformatf("mul s%0d m1", s), 1'b0, s[0], 1'b1, 1'b1,
				32'hffff_ffff, 32'hffff_ffff);
			for (int n = 0; n < 3; n++)
				run_long($sformatf("mul s%0d rnd%0d", s, n), 1'b0, s[0], 1'b1, 1'b1,
					$random(seed), $random(seed));
			run_long($sformatf("div s%0d neg", s), 1'b1, s[0], 1'b1, 1'b1,
				32'hffff_fff9, 32'h2);
			run_long($sformatf("div s%0d negdvs", s), 1'b1, s[0], 1'b1, 1'b1,
				32'h7, 32'hffff_fffe);
			run_long($sformatf("div s%0d zero", s), 1'b1, s[0], 1'b1, 1'b1,
				32'h8000_0005, 32'h0);
			run_long($sformatf("div s%0d min", s), 1'b1, s[0], 1'b1, 1'b1,
				32'h8000_0000, 32'hffff_ffff);
			run_long($sformatf("div s%0d rnd", s), 1'b1, s[0], 1'b1, 1'b1,
				$random(seed), $random(seed) | 32'h1);
		end
		mul_burst();

		// Moves from rs and a disabled LO write across a multiply
		write_rs("mthi", 1'b1, 32'hcafe_0001);
		write_rs("mtlo", 1'b0, 32'h1234_5678);
		run_long("mul lo kept", 1'b0, 1'b0, 1'b1, 1'b0, 32'h0001_0000, 32'h0003_0000);

		// Destination register selection and forwarded fields
		c = '0;
		for (int r = 0; r < 3; r++) begin
			c.regdst = ex_pkg::regdst_e'(2'(r));
			c.regwrite = r[0];
			c.hi_wen = r[1];
			c.lo_wen = r[0];
			d = make_dtoe(16'h0, 5'd0);
			d.pc = 32'h0000_1000 + 32'(r * 4);
			d.in_delay_slot = r[0];
			op_a = $random(seed);
			op_b = $random(seed);
			drive(c, d, op_a, op_b);
			exp = ex_model(c, d, op_a, op_b, hi_m, lo_m);
			@(negedge clk);
			chk0.check_waddr({"regdst ", c.regdst.name()}, exp.waddr);
			chk0.compare_passthru({"fields ", c.regdst.name()}, c, d, op_a, op_b);
		end

		chk0.summary();
		if (chk0.n_fail == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+src
src/ex_pkg.sv
src/alu.sv
src/shifter.sv
src/multiplier.sv
src/divider.sv
src/ex.sv
src/hilo_regs.sv
src/ex_top.sv
bench/ex_assert.sv
bench/ex_checker.sv
bench/tb_ex.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) flist.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f flist.f

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
